// ==== ts_pkg.sv ====
package ts_pkg;

    // word address width of the external DRAM
    localparam int DRAM_ADDR_W = 21;

    // address width of one line buffer bank (512 entries)
    localparam int LINE_ADDR_W = 9;

    // render task as posted by the host
    typedef struct packed {
        // first TS-line address the sprite lands on
        logic [LINE_ADDR_W-1:0] x_coord;
        // render cycles minus one, one cycle is 8 pixels
        logic [2:0]             x_size;
        // mirror the sprite in X
        logic                   flip;
        // dword within the bitmap line
        logic [5:0]             addr;
        // bitmap line, already resolved by the host
        logic [8:0]             line;
        // first bitmap page, bits 2..0 ignored
        logic [7:0]             page;
        // palette selector, upper nibble of the CRAM index
        logic [3:0]             pal;
    } ts_task_t;

    // four phases of one DRAM cycle
    typedef enum logic [1:0] {
        c0 = 2'd0,
        c1 = 2'd1,
        c2 = 2'd2,
        c3 = 2'd3
    } dram_phase_t;

    // read request toward the external memory
    typedef struct packed {
        logic                   en;
        logic [DRAM_ADDR_W-1:0] addr;
    } dram_rd_t;

    // pixel write into the line buffer
    typedef struct packed {
        logic                   we;
        logic [LINE_ADDR_W-1:0] waddr;
        // palette in 7..4, pixel in 3..0
        logic [7:0]             wdata;
    } ts_wr_t;

endpackage

// ==== ts_task_queue.sv ====
module ts_task_queue #(
    parameter int TASK_DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             line_start,
    input  logic             task_valid,
    input  ts_pkg::ts_task_t task_data,
    input  logic             mem_rdy,
    output logic             tsr_go,
    output ts_pkg::ts_task_t tsr_task,
    output logic             task_overflow
);

    // a depth of one still needs a one bit pointer
    localparam int PTR_W = (TASK_DEPTH > 1) ? $clog2(TASK_DEPTH) : 1;
    localparam int CNT_W = $clog2(TASK_DEPTH + 1);

    ts_pkg::ts_task_t fifo [TASK_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    logic             go_d;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(TASK_DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    assign full  = (count == CNT_W'(TASK_DEPTH));
    assign empty = (count == '0);

    // a task arriving on a full queue is lost
    assign push = task_valid && !full && !line_start;

    // renderer ready and no start in flight from the last clock
    assign pop = !empty && mem_rdy && !go_d && !line_start;

    assign tsr_go   = pop;
    assign tsr_task = fifo[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset || line_start)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            // count only moves when exactly one side is active
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // task storage
    always_ff @(posedge clk)
    begin
        if (push)
            fifo[wr_ptr] <= task_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            go_d <= 1'b0;
        else
            go_d <= pop;
    end

    // sticky until the next line
    always_ff @(posedge clk)
    begin
        if (reset || line_start)
            task_overflow <= 1'b0;
        else if (task_valid && full)
            task_overflow <= 1'b1;
    end

endmodule

// ==== ts_render.sv ====
module ts_render (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           line_start,
    input  logic                           tsr_go,
    input  ts_pkg::ts_task_t               tsr_task,
    output logic                           mem_rdy,
    output logic                           dram_req,
    output logic [ts_pkg::DRAM_ADDR_W-1:0] dram_addr,
    input  logic [15:0]                    dram_rdata,
    input  logic                           dram_pre_next,
    input  logic                           dram_next,
    output ts_pkg::ts_wr_t                 ts_wr
);

    logic                           init;
    logic [1:0]                     abort_cnt;
    logic                           strobe_ok;
    logic                           pre_next_ok;
    logic                           next_ok;
    logic [4:0]                     word_cnt;
    logic [ts_pkg::DRAM_ADDR_W-1:0] addr_start;
    logic [ts_pkg::DRAM_ADDR_W-1:0] addr_reg;
    logic [15:0]                    data_reg;
    logic [2:0]                     pix_cnt;
    logic                           render_on;
    logic                           reload;
    logic                           reload_stb;
    logic [ts_pkg::LINE_ADDR_W-1:0] start_x_d;
    logic [3:0]                     pal_d;
    logic                           flip_d;
    logic [ts_pkg::LINE_ADDR_W-1:0] waddr;
    logic [3:0]                     pal_r;
    logic                           flip_r;
    logic [3:0]                     pix;

    // line start aborts the task the same way reset does
    assign init = reset || line_start;

    // after an abort, a word already in flight in the DRAM port
    // still strobes for up to 3 clocks and must be ignored
    always_ff @(posedge clk)
    begin
        if (reset)
            abort_cnt <= 2'd0;
        else if (line_start)
            abort_cnt <= 2'd3;
        else if (abort_cnt != 2'd0)
            abort_cnt <= abort_cnt - 2'd1;
    end

    assign strobe_ok   = (abort_cnt == 2'd0);
    assign pre_next_ok = dram_pre_next && strobe_ok;
    assign next_ok     = dram_next && strobe_ok;

    // words left, bit 4 set means nothing left to fetch
    // loaded with 2 * (x_size + 1) - 1
    always_ff @(posedge clk)
    begin
        if (init)
            word_cnt <= 5'b10000;
        else if (tsr_go)
            word_cnt <= {1'b0, tsr_task.x_size, 1'b1};
        else if (pre_next_ok)
            word_cnt <= word_cnt - 5'd1;
    end

    assign mem_rdy  = word_cnt[4] && strobe_ok;
    assign dram_req = tsr_go || !word_cnt[4];

    // page[7:3], line, dword, word-in-dword
    assign addr_start = {tsr_task.page[7:3], tsr_task.line, tsr_task.addr, 1'b0};

    // only the low 7 bits step, a sprite never leaves its bitmap line
    // address is held until next, then steps on that very clock
    assign dram_addr = tsr_go ? addr_start
                              : {addr_reg[20:7], addr_reg[6:0] + 7'(next_ok)};

    always_ff @(posedge clk)
    begin
        addr_reg <= dram_addr;
    end

    // word to serialize
    always_ff @(posedge clk)
    begin
        if (next_ok)
            data_reg <= dram_rdata;
    end

    // pixel counter, bit 2 set means idle
    assign render_on = !pix_cnt[2];

    always_ff @(posedge clk)
    begin
        if (init)
            pix_cnt <= 3'b100;
        else if (next_ok)
            pix_cnt <= 3'b000;
        else if (render_on)
            pix_cnt <= pix_cnt + 3'd1;
    end

    // armed by go, fires on the first word of the new task
    always_ff @(posedge clk)
    begin
        if (init)
            reload <= 1'b0;
        else if (tsr_go)
            reload <= 1'b1;
        else if (next_ok)
            reload <= 1'b0;
    end

    assign reload_stb = reload && next_ok;

    // task fields held until the first word shows up
    // flipped sprites start at their right edge
    always_ff @(posedge clk)
    begin
        if (tsr_go)
        begin
            start_x_d <= tsr_task.x_coord
                       + (tsr_task.flip ? {3'd0, tsr_task.x_size, 3'b111} : 9'd0);
            pal_d     <= tsr_task.pal;
            flip_d    <= tsr_task.flip;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reload_stb)
        begin
            pal_r  <= pal_d;
            flip_r <= flip_d;
        end
    end

    // +1 or -1 step, wraps at 512
    always_ff @(posedge clk)
    begin
        if (reload_stb)
            waddr <= start_x_d;
        else if (render_on)
            waddr <= waddr + {{8{flip_r}}, 1'b1};
    end

    // nibble order inside the word
    always_comb
    begin
        case (pix_cnt[1:0])
            2'd0: pix = data_reg[7:4];
            2'd1: pix = data_reg[3:0];
            2'd2: pix = data_reg[15:12];
            default: pix = data_reg[11:8];
        endcase
    end

    // pixel 0 is transparent
    always_comb
    begin
        ts_wr.we    = render_on && (pix != 4'd0);
        ts_wr.waddr = waddr;
        ts_wr.wdata = {pal_r, pix};
    end

endmodule

// ==== ts_dram_port.sv ====
module ts_dram_port (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dram_req,
    input  logic [ts_pkg::DRAM_ADDR_W-1:0] dram_addr,
    output ts_pkg::dram_rd_t               mem_rd,
    input  logic [15:0]                    mem_rdata,
    output logic [15:0]                    dram_rdata,
    output logic                           dram_pre_next,
    output logic                           dram_next
);

    ts_pkg::dram_phase_t            phase;
    logic                           active;
    logic [ts_pkg::DRAM_ADDR_W-1:0] addr_lat;
    logic [15:0]                    data_lat;

    // phases run free, a cycle is used only if requested at c0
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase  <= ts_pkg::c0;
            active <= 1'b0;
        end
        else
        begin
            phase <= ts_pkg::dram_phase_t'(phase + 2'd1);
            if (phase == ts_pkg::c0)
                active <= dram_req;
        end
    end

    // address sampled at c0, presented during c1
    always_ff @(posedge clk)
    begin
        if (phase == ts_pkg::c0 && dram_req)
            addr_lat <= dram_addr;
    end

    // memory answers during c2, held for the renderer through c3
    always_ff @(posedge clk)
    begin
        if (phase == ts_pkg::c2 && active)
            data_lat <= mem_rdata;
    end

    always_comb
    begin
        mem_rd.en   = active && (phase == ts_pkg::c1);
        mem_rd.addr = addr_lat;
    end

    // pre_next lets the renderer count words one phase early
    assign dram_pre_next = active && (phase == ts_pkg::c2);
    assign dram_next     = active && (phase == ts_pkg::c3);
    assign dram_rdata    = data_lat;

endmodule

// ==== ts_line_buffer.sv ====
module ts_line_buffer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           line_start,
    input  ts_pkg::ts_wr_t                 ts_wr,
    input  logic                           disp_rd,
    input  logic [ts_pkg::LINE_ADDR_W-1:0] disp_addr,
    output logic [7:0]                     disp_data
);

    localparam int LINE_LEN = 1 << ts_pkg::LINE_ADDR_W;

    // two banks, index 0 and 1
    logic [7:0] mem [2][LINE_LEN];

    // bank currently taking renderer writes
    logic render_bank;
    logic disp_bank;

    always_ff @(posedge clk)
    begin
        if (reset)
            render_bank <= 1'b0;
        else if (line_start)
            render_bank <= !render_bank;
    end

    // display always works on the other bank
    assign disp_bank = !render_bank;

    // renderer write and display clear never hit the same bank
    always_ff @(posedge clk)
    begin
        if (ts_wr.we)
            mem[render_bank][ts_wr.waddr] <= ts_wr.wdata;
        if (disp_rd)
            mem[disp_bank][disp_addr] <= 8'd0;
    end

    // one clock read latency, old value returned before the clear
    always_ff @(posedge clk)
    begin
        if (disp_rd)
            disp_data <= mem[disp_bank][disp_addr];
    end

endmodule

// ==== ts_subsystem.sv ====
module ts_subsystem #(
    parameter int TASK_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           line_start,
    input  logic                           task_valid,
    input  ts_pkg::ts_task_t               task_data,
    output logic                           task_overflow,
    output ts_pkg::dram_rd_t               mem_rd,
    input  logic [15:0]                    mem_rdata,
    input  logic                           disp_rd,
    input  logic [ts_pkg::LINE_ADDR_W-1:0] disp_addr,
    output logic [7:0]                     disp_data
);

    // queue to renderer
    logic                           tsr_go;
    ts_pkg::ts_task_t               tsr_task;
    logic                           mem_rdy;

    // renderer to DRAM port
    logic                           dram_req;
    logic [ts_pkg::DRAM_ADDR_W-1:0] dram_addr;
    logic [15:0]                    dram_rdata;
    logic                           dram_pre_next;
    logic                           dram_next;

    // renderer to line buffer
    ts_pkg::ts_wr_t                 ts_wr;

    ts_task_queue #(
        .TASK_DEPTH (TASK_DEPTH)
    ) u_task_queue (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .task_valid    (task_valid),
        .task_data     (task_data),
        .mem_rdy       (mem_rdy),
        .tsr_go        (tsr_go),
        .tsr_task      (tsr_task),
        .task_overflow (task_overflow)
    );

    ts_render u_render (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .tsr_go        (tsr_go),
        .tsr_task      (tsr_task),
        .mem_rdy       (mem_rdy),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .dram_rdata    (dram_rdata),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next),
        .ts_wr         (ts_wr)
    );

    ts_dram_port u_dram_port (
        .clk           (clk),
        .reset         (reset),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .mem_rd        (mem_rd),
        .mem_rdata     (mem_rdata),
        .dram_rdata    (dram_rdata),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next)
    );

    ts_line_buffer u_line_buffer (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .ts_wr      (ts_wr),
        .disp_rd    (disp_rd),
        .disp_addr  (disp_addr),
        .disp_data  (disp_data)
    );

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model (
    input  logic             clk,
    input  logic             reset,
    input  ts_pkg::dram_rd_t mem_rd,
    output logic [15:0]      mem_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    // word content is a pure function of the word address
    // low 16 bits of A * 9e37, xor A >> 5
    function automatic logic [15:0] word_at(input logic [ts_pkg::DRAM_ADDR_W-1:0] a);
        logic [31:0] prod;
        logic [31:0] shifted;
        prod    = 32'(a) * 32'h9e37;
        shifted = 32'(a) >> 5;
        return prod[15:0] ^ shifted[15:0];
    endfunction

    // synchronous read port, data valid only on the clock after en
    // all other clocks carry X so a late or early sample shows up
    always_ff @(posedge clk)
    begin
        if (reset)
            mem_rdata <= '0;
        else if (mem_rd.en)
            mem_rdata <= word_at(mem_rd.addr);
        else
            mem_rdata <= 'x;
    end

endmodule

// ==== tb_ts_subsystem.sv ====
module tb_ts_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TASK_DEPTH   = 4;
    localparam int IDLE_TIMEOUT = 5000;
    localparam int LINE_LEN     = 512;

    logic                           clk;
    logic                           reset;
    logic                           line_start;
    logic                           task_valid;
    ts_pkg::ts_task_t               task_data;
    logic                           task_overflow;
    ts_pkg::dram_rd_t               mem_rd;
    logic [15:0]                    mem_rdata;
    logic                           disp_rd;
    logic [ts_pkg::LINE_ADDR_W-1:0] disp_addr;
    logic [7:0]                     disp_data;

    integer seed = 32'h8c77;
    int     errors = 0;
    int     err_start = 0;
    int     tests_run = 0;
    int     tests_failing = 0;
    int     cycle = 0;

    // expected line and expected DRAM word addresses
    logic [7:0]                     line_model [LINE_LEN];
    logic [ts_pkg::DRAM_ADDR_W-1:0] exp_addrs [$];
    // what the DUT actually fetched, and when
    logic [ts_pkg::DRAM_ADDR_W-1:0] got_addrs [$];
    int                             en_cycles [$];
    // tasks waiting to be posted in consecutive cycles
    ts_pkg::ts_task_t               post_q [$];

    ts_subsystem #(
        .TASK_DEPTH (TASK_DEPTH)
    ) u_ts_subsystem (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .task_valid    (task_valid),
        .task_data     (task_data),
        .task_overflow (task_overflow),
        .mem_rd        (mem_rd),
        .mem_rdata     (mem_rdata),
        .disp_rd       (disp_rd),
        .disp_addr     (disp_addr),
        .disp_data     (disp_data)
    );

    tb_mem_model u_mem_model (
        .clk       (clk),
        .reset     (reset),
        .mem_rd    (mem_rd),
        .mem_rdata (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // DRAM read monitor, sampled away from the active edge
    always @(negedge clk)
    begin
        cycle = cycle + 1;
        if (mem_rd.en === 1'b1)
        begin
            got_addrs.push_back(mem_rd.addr);
            en_cycles.push_back(cycle);
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // independent copy of the memory rule
    function automatic logic [15:0] expected_word(input logic [20:0] a);
        logic [31:0] prod;
        logic [31:0] shifted;
        prod    = 32'(a) * 32'h9e37;
        shifted = 32'(a) >> 5;
        return prod[15:0] ^ shifted[15:0];
    endfunction

    function automatic ts_pkg::ts_task_t random_task(input logic [8:0] x, input logic [2:0] xs,
                                                     input logic fl);
        ts_pkg::ts_task_t t;
        logic [31:0]      r;
        r         = rnd();
        t.x_coord = x;
        t.x_size  = xs;
        t.flip    = fl;
        t.addr    = r[5:0];
        t.line    = r[14:6];
        t.page    = r[22:15];
        t.pal     = r[26:23];
        return t;
    endfunction

    // line model, renders one task on top of what is already there
    function automatic void model_task(input ts_pkg::ts_task_t t);
        logic [20:0] base;
        logic [20:0] a;
        logic [15:0] w;
        logic [3:0]  p;
        logic [8:0]  x;
        int          nw;
        int          i;
        int          k;
        int          n;
        base = {t.page[7:3], t.line, t.addr, 1'b0};
        nw   = 2 * (int'(t.x_size) + 1);
        for (i = 0; i < nw; i++)
        begin
            // only the low 7 bits count up
            a = {base[20:7], 7'(int'(base[6:0]) + i)};
            exp_addrs.push_back(a);
            w = expected_word(a);
            for (k = 0; k < 4; k++)
            begin
                case (k)
                    0: p = w[7:4];
                    1: p = w[3:0];
                    2: p = w[15:12];
                    default: p = w[11:8];
                endcase
                n = 4 * i + k;
                if (t.flip)
                    x = 9'(int'(t.x_coord) + 8 * int'(t.x_size) + 7 - n);
                else
                    x = 9'(int'(t.x_coord) + n);
                // zero is transparent
                if (p != 4'd0)
                    line_model[x] = {t.pal, p};
            end
        end
    endfunction

    task automatic begin_test();
        int a;
        err_start = errors;
        exp_addrs.delete();
        got_addrs.delete();
        en_cycles.delete();
        for (a = 0; a < LINE_LEN; a++)
            line_model[a] = 8'd0;
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (errors != err_start)
            tests_failing = tests_failing + 1;
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
    endtask

    // post the queued tasks on consecutive clocks
    task automatic post_all();
        int i;
        for (i = 0; i < post_q.size(); i++)
        begin
            @(posedge clk);
            #1;
            task_valid = 1'b1;
            task_data  = post_q[i];
            // first one goes straight to the idle renderer,
            // the FIFO holds TASK_DEPTH behind it and the rest is lost
            if (i <= TASK_DEPTH)
                model_task(post_q[i]);
        end
        @(posedge clk);
        #1;
        task_valid = 1'b0;
        post_q.delete();
    endtask

    // idle once 16 clocks pass without a DRAM read
    task automatic wait_idle();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 16 && n < IDLE_TIMEOUT)
        begin
            @(negedge clk);
            n = n + 1;
            if (mem_rd.en === 1'b1)
                quiet = 0;
            else
                quiet = quiet + 1;
        end
        if (quiet < 16)
        begin
            errors = errors + 1;
            $display("timeout: DUT still reading DRAM after %0d clocks", n);
        end
    endtask

    task automatic pulse_line_start();
        @(posedge clk);
        #1;
        line_start = 1'b1;
        @(posedge clk);
        #1;
        line_start = 1'b0;
    endtask

    // one entry at a time, data one clock after the read
    task automatic read_line(input bit check);
        int a;
        for (a = 0; a < LINE_LEN; a++)
        begin
            @(posedge clk);
            #1;
            disp_rd   = 1'b1;
            disp_addr = 9'(a);
            @(posedge clk);
            #1;
            disp_rd = 1'b0;
            if (check && disp_data !== line_model[a])
            begin
                errors = errors + 1;
                $display("Mismatch disp_data addr %03h got %02h exp %02h",
                         a, disp_data, line_model[a]);
            end
        end
    endtask

    task automatic check_fetches();
        int i;
        if (got_addrs.size() != exp_addrs.size())
        begin
            errors = errors + 1;
            $display("wrong number of DRAM reads: got %0d, expected %0d",
                     got_addrs.size(), exp_addrs.size());
        end
        for (i = 0; i < got_addrs.size() && i < exp_addrs.size(); i++)
        begin
            if (got_addrs[i] !== exp_addrs[i])
            begin
                errors = errors + 1;
                $display("Mismatch mem_rd.addr word %0d got %06h exp %06h",
                         i, got_addrs[i], exp_addrs[i]);
            end
        end
    endtask

    // render, swap the banks, check the line
    task automatic run_line();
        wait_idle();
        check_fetches();
        pulse_line_start();
        read_line(1'b1);
    endtask

    task automatic test_unflipped();
        logic [31:0] r;
        begin_test();
        r = rnd();
        post_q.push_back(random_task(r[8:0], r[11:9], 1'b0));
        post_all();
        run_line();
        end_test("unflipped sprite");
    endtask

    task automatic test_flipped();
        logic [31:0] r;
        logic [2:0]  xs;
        logic [8:0]  x;
        begin_test();
        r  = rnd();
        xs = 3'd2 + 3'(r[2:0] % 6);
        // right edge lands on 1..6, so the walk down crosses 0 to 511
        x  = 9'(505 - 8 * int'(xs) + 1 + int'(r[5:3] % 6));
        post_q.push_back(random_task(x, xs, 1'b1));
        post_all();
        run_line();
        end_test("flipped sprite with wrap");
    endtask

    task automatic test_overlap();
        begin_test();
        post_q.push_back(random_task(9'd100, 3'd3, 1'b0));
        post_q.push_back(random_task(9'd112, 3'd2, 1'b1));
        post_all();
        run_line();
        end_test("overlapping sprites");
    endtask

    task automatic test_back_to_back();
        logic [31:0] r;
        int          i;
        begin_test();
        for (i = 0; i < 4; i++)
        begin
            r = rnd();
            post_q.push_back(random_task(r[8:0], r[11:9], r[12]));
        end
        post_all();
        wait_idle();
        // one word per four-phase DRAM cycle, no gaps between tasks
        for (i = 1; i < en_cycles.size(); i++)
        begin
            if (en_cycles[i] - en_cycles[i-1] != 4)
            begin
                errors = errors + 1;
                $display("Mismatch mem_rd.en gap word %0d got %0h exp %0h",
                         i, en_cycles[i] - en_cycles[i-1], 4);
            end
        end
        check_fetches();
        pulse_line_start();
        read_line(1'b1);
        end_test("four tasks back to back");
    endtask

    task automatic test_clear_on_read();
        logic [31:0] r;
        int          a;
        begin_test();
        r = rnd();
        post_q.push_back(random_task(r[8:0], r[11:9], r[12]));
        post_all();
        run_line();
        // same bank comes back to the display after two more swaps
        pulse_line_start();
        pulse_line_start();
        for (a = 0; a < LINE_LEN; a++)
            line_model[a] = 8'd0;
        read_line(1'b1);
        end_test("clear on read");
    endtask

    task automatic test_overflow();
        logic [31:0] r;
        int          i;
        begin_test();
        for (i = 0; i < TASK_DEPTH + 2; i++)
        begin
            r = rnd();
            post_q.push_back(random_task(r[8:0], r[11:9], r[12]));
        end
        post_all();
        if (task_overflow !== 1'b1)
        begin
            errors = errors + 1;
            $display("Mismatch task_overflow got %h exp %h", task_overflow, 1'b1);
        end
        run_line();
        if (task_overflow !== 1'b0)
        begin
            errors = errors + 1;
            $display("Mismatch task_overflow got %h exp %h", task_overflow, 1'b0);
        end
        end_test("queue overflow");
    endtask

    initial
    begin
        reset      = 1'b1;
        line_start = 1'b0;
        task_valid = 1'b0;
        task_data  = '0;
        disp_rd    = 1'b0;
        disp_addr  = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // banks power up unknown, a read pass over each clears it
        pulse_line_start();
        read_line(1'b0);
        pulse_line_start();
        read_line(1'b0);

        test_unflipped();
        test_flipped();
        test_overlap();
        test_back_to_back();
        test_clear_on_read();
        test_overflow();

        $display("tests %0d, failing tests %0d, errors %0d", tests_run, tests_failing, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
ts_pkg.sv
ts_task_queue.sv
ts_render.sv
ts_dram_port.sv
ts_line_buffer.sv
ts_subsystem.sv
tb_mem_model.sv
tb_ts_subsystem.sv
